/* alu_pipe.sv */
`timescale 1ns/10ps
`include "lshape_macros.svh"

module alu_pipe (
  input  logic                    clk,
  input  logic                    rst,
  input  lshape_op_pkg::alu_req_t req,
  output lshape_op_pkg::alu_rsp_t rsp
);

  import lshape_op_pkg::*;

  // first stage is the compute register below
  localparam int tail_lat = `LS_PIPE_DEPTH - 1;

  logic [`LS_DATA_W-1:0] sum;
  alu_rsp_t              rsp_d;
  alu_rsp_t              rsp_q;

  always_comb begin
    sum = req.add ? (req.a + req.b) : (req.a - req.b);
    rsp_d.result = sum;
    rsp_d.z = (sum == '0);
    rsp_d.n = sum[`LS_DATA_W-1];
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_d;  // sampled every cycle, qualified downstream
    end
  end

  delay_line #(
    .lat  (tail_lat),
    .width($bits(alu_rsp_t))
  ) i_rsp_dly (
    .clk,
    .rst,
    .din (rsp_q),
    .dout(rsp)
  );

endmodule

/* build.f */
+incdir+.
lshape_op_pkg.sv
lshape_flow_pkg.sv
delay_line.sv
alu_pipe.sv
credit_pipe.sv
result_fifo.sv
lshape_top.sv
lshape_checker.sv
tb_lshape.sv

/* credit_pipe.sv */
`timescale 1ns/10ps
`include "lshape_macros.svh"

module credit_pipe (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  us_valid,
  input  lshape_op_pkg::tag_t   us_tag,
  output logic                  us_stall,
  input  lshape_flow_pkg::occ_t num_in_fifo,
  output logic                  pipe_valid,
  output lshape_op_pkg::tag_t   pipe_tag
);

  import lshape_op_pkg::*;
  import lshape_flow_pkg::*;

  localparam int   depth      = `LS_PIPE_DEPTH;
  localparam occ_t fifo_slots = occ_t'(1 << `LS_FIFO_K);

  logic             accept;
  logic [depth-1:0] valid_chain;
  occ_t             in_flight;
  occ_t             credits_used;

  assign accept = us_valid & ~us_stall;

  // both terms are registers, so stall depends on state only
  assign credits_used = in_flight + num_in_fifo;
  assign us_stall = (credits_used >= fifo_slots);

  assign pipe_valid = valid_chain[depth-1];

  // accept strobe enters at bit 0, leaves as the fifo write
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_chain <= '0;
    end else begin
      valid_chain <= {valid_chain[depth-2:0], accept};
    end
  end

  // a leaving entry moves its credit into num_in_fifo on the same edge
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      case ({accept, pipe_valid})
        2'b10:   in_flight <= in_flight + occ_t'(1);
        2'b01:   in_flight <= in_flight - occ_t'(1);
        default: in_flight <= in_flight;  // none, or one in and one out
      endcase
    end
  end

  delay_line #(
    .lat  (depth),
    .width($bits(tag_t))
  ) i_tag_dly (
    .clk,
    .rst,
    .din (us_tag),
    .dout(pipe_tag)
  );

endmodule

/* delay_line.sv */
`timescale 1ns/10ps

module delay_line #(
  parameter int lat   = 1,
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [width-1:0] din,
  output logic [width-1:0] dout
);

  logic [lat-1:0][width-1:0] stage;

  assign dout = stage[lat-1];

  // free running, no enable
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      stage <= '0;
    end else begin
      stage[0] <= din;
      for (int i = 1; i < lat; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

endmodule

/* lshape_checker.sv */
`timescale 1ns/10ps
`include "lshape_macros.svh"

module lshape_checker (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         us_valid,
  input  lshape_op_pkg::alu_req_t      us_req,
  input  lshape_op_pkg::tag_t          us_tag,
  input  logic                         us_stall,
  input  logic                         rdreq,
  input  logic                         empty,
  input  lshape_flow_pkg::fifo_entry_t ds_entry,
  output int                           errors,
  output int                           accepts,
  output int                           pops
);

  import lshape_op_pkg::*;
  import lshape_flow_pkg::*;

  localparam int depth = `LS_PIPE_DEPTH;
  localparam int slots = 1 << `LS_FIFO_K;

  fifo_entry_t      expected_q[$];
  fifo_entry_t      head;
  logic [depth-1:0] arrive_sr;  // accepts on their way to the fifo
  logic             accept_now;
  logic             pop_now;
  logic             arrive_now;
  int               m_in_flight;
  int               m_count;
  int               err_cnt = 0;
  int               acc_cnt = 0;
  int               pop_cnt = 0;

  assign errors = err_cnt;
  assign accepts = acc_cnt;
  assign pops = pop_cnt;

  // full-width integer math, wrapped to the result width afterwards
  function automatic fifo_entry_t model_entry(alu_req_t req, tag_t tag);
    fifo_entry_t e;
    int          full_sum;
    full_sum = req.add ? int'(req.a) + int'(req.b) : int'(req.a) - int'(req.b);
    e.tag = tag;
    e.rsp.result = full_sum[`LS_DATA_W-1:0];
    e.rsp.z = (e.rsp.result == '0);
    e.rsp.n = e.rsp.result[`LS_DATA_W-1];
    return e;
  endfunction

  task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      arrive_sr = '0;
      m_in_flight = 0;
      m_count = 0;
      expected_q.delete();
    end else begin
      // values seen here are what the previous edge left
      compare_value("empty", 32'(m_count == 0), 32'(empty));
      compare_value("us_stall", 32'((m_in_flight + m_count) >= slots), 32'(us_stall));
      accept_now = us_valid & ~us_stall;
      pop_now = rdreq & ~empty;
      arrive_now = arrive_sr[depth-1];
      if (accept_now) begin
        expected_q.push_back(model_entry(us_req, us_tag));
        acc_cnt++;
      end
      if (pop_now) begin
        pop_cnt++;
        if (expected_q.size() == 0) begin
          err_cnt++;
          $display("At %0t an entry was popped although no result was expected", $time);
        end else begin
          head = expected_q.pop_front();
          compare_value("ds_entry", 32'(head), 32'(ds_entry));
        end
      end
      arrive_sr = {arrive_sr[depth-2:0], accept_now};
      m_in_flight = m_in_flight + int'(accept_now) - int'(arrive_now);
      m_count = m_count + int'(arrive_now) - int'(pop_now);
    end
  end

endmodule

/* lshape_flow_pkg.sv */
`include "lshape_macros.svh"

package lshape_flow_pkg;

  // tag in the upper bits, arithmetic outcome below
  typedef struct packed {
    lshape_op_pkg::tag_t     tag;
    lshape_op_pkg::alu_rsp_t rsp;
  } fifo_entry_t;

  // in-flight or stored count, pipe depth + fifo depth + 1 fits
  typedef logic [$clog2(`LS_PIPE_DEPTH + (1 << `LS_FIFO_K) + 1)-1:0] occ_t;

endpackage

/* lshape_macros.svh */
`ifndef LS_MACROS_SVH
`define LS_MACROS_SVH

// operand and result width
`define LS_DATA_W 16

// request tag width
`define LS_TAG_W 8

// cycles from accept to FIFO write
`define LS_PIPE_DEPTH 6

// FIFO holds 2**K entries
`define LS_FIFO_K 2

`endif

/* lshape_op_pkg.sv */
`include "lshape_macros.svh"

package lshape_op_pkg;

  // carried beside the datapath, returned with the result
  typedef logic [`LS_TAG_W-1:0] tag_t;

  typedef struct packed {
    logic [`LS_DATA_W-1:0] a;
    logic [`LS_DATA_W-1:0] b;
    logic                  add;     // 1 = a + b, 0 = a - b
  } alu_req_t;

  typedef struct packed {
    logic [`LS_DATA_W-1:0] result;  // wraps, no carry kept
    logic                  z;       // result is zero
    logic                  n;       // msb of result
  } alu_rsp_t;

endpackage

/* lshape_top.sv */
`timescale 1ns/10ps

module lshape_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         us_valid,
  input  lshape_op_pkg::alu_req_t      us_req,
  input  lshape_op_pkg::tag_t          us_tag,
  output logic                         us_stall,
  input  logic                         rdreq,
  output logic                         empty,
  output lshape_flow_pkg::fifo_entry_t ds_entry
);

  import lshape_op_pkg::*;
  import lshape_flow_pkg::*;

  logic        pipe_valid;
  tag_t        pipe_tag;
  alu_rsp_t    alu_rsp;
  fifo_entry_t fifo_wdata;
  occ_t        num_in_fifo;

  // tag and result arrive on the same cycle
  assign fifo_wdata.tag = pipe_tag;
  assign fifo_wdata.rsp = alu_rsp;

  credit_pipe i_credit (
    .clk,
    .rst,
    .us_valid,
    .us_tag,
    .us_stall,
    .num_in_fifo,
    .pipe_valid,
    .pipe_tag
  );

  // operands flow every cycle, no stall
  alu_pipe i_alu (
    .clk,
    .rst,
    .req(us_req),
    .rsp(alu_rsp)
  );

  result_fifo i_fifo (
    .clk,
    .rst,
    .wr   (pipe_valid),
    .wdata(fifo_wdata),
    .rd   (rdreq),
    .rdata(ds_entry),
    .empty,
    .num_in_fifo
  );

endmodule

/* result_fifo.sv */
`timescale 1ns/10ps
`include "lshape_macros.svh"

module result_fifo (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         wr,
  input  lshape_flow_pkg::fifo_entry_t wdata,
  input  logic                         rd,
  output lshape_flow_pkg::fifo_entry_t rdata,
  output logic                         empty,
  output lshape_flow_pkg::occ_t        num_in_fifo
);

  import lshape_flow_pkg::*;

  localparam int k     = `LS_FIFO_K;
  localparam int slots = 1 << k;

  // top bit of each pointer is the wrap bit
  logic [k:0]                   rd_ptr;
  logic [k:0]                   wr_ptr;
  logic                         full;
  logic                         wr_ok;
  logic                         rd_ok;
  fifo_entry_t [slots-1:0]      mem;
  occ_t                         count;

  assign empty = (rd_ptr == wr_ptr);
  assign full = (rd_ptr == {~wr_ptr[k], wr_ptr[k-1:0]});

  // credits upstream keep wr away from a full fifo
  assign wr_ok = wr & ~full;
  assign rd_ok = rd & ~empty;  // pop on empty is dropped

  assign rdata = mem[rd_ptr[k-1:0]];
  assign num_in_fifo = count;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + (k+1)'(1);
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + (k+1)'(1);
      end
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + occ_t'(1);
        2'b01:   count <= count - occ_t'(1);
        default: count <= count;
      endcase
    end
  end

  // write and read share a slot only when empty or full
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      mem <= '0;
    end else begin
      if (wr_ok) begin
        mem[wr_ptr[k-1:0]] <= wdata;
      end
      if (rd_ok) begin
        mem[rd_ptr[k-1:0]] <= '0;  // popped slot cleared
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_lshape -o sim_lshape

out=$(./obj_dir/sim_lshape)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
else
  exit 1
fi

/* tb_lshape.sv */
`timescale 1ns/10ps
`include "lshape_macros.svh"

module tb_lshape;

  import lshape_op_pkg::*;
  import lshape_flow_pkg::*;

  localparam int wait_limit = 200;
  localparam int fifo_slots = 1 << `LS_FIFO_K;

  logic        clk;
  logic        rst;
  logic        us_valid;
  alu_req_t    us_req;
  tag_t        us_tag;
  logic        us_stall;
  logic        rdreq;
  logic        empty;
  fifo_entry_t ds_entry;
  int          chk_errors;
  int          accepts;
  int          pops;
  int          tb_errors;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  lshape_top i_dut (
    .clk,
    .rst,
    .us_valid,
    .us_req,
    .us_tag,
    .us_stall,
    .rdreq,
    .empty,
    .ds_entry
  );

  lshape_checker i_chk (
    .clk,
    .rst,
    .us_valid,
    .us_req,
    .us_tag,
    .us_stall,
    .rdreq,
    .empty,
    .ds_entry,
    .errors (chk_errors),
    .accepts(accepts),
    .pops   (pops)
  );

  // biased towards zero and negative results now and then
  task automatic set_random_req();
    alu_req_t r;
    int       pick;
    pick = $urandom_range(0, 3);
    r.a = 16'($urandom);
    r.b = 16'($urandom);
    r.add = 1'($urandom);
    if (pick == 0) begin
      r.b = r.a;  // a - a
      r.add = 1'b0;
    end else if (pick == 1) begin
      r.a = r.a & 16'h00ff;
      r.b = (r.b & 16'h7fff) | 16'h0100;  // b above a, difference below 2**15
      r.add = 1'b0;
    end
    us_req <= r;
    us_tag <= tag_t'($urandom);
  endtask

  // returns on the accepting edge
  task automatic send_one();
    int n;
    n = 0;
    @(posedge clk);
    set_random_req();
    us_valid <= 1'b1;
    @(posedge clk);
    while (us_stall) begin
      n++;
      if (n > wait_limit) begin
        tb_errors++;
        $display("A request was not accepted within %0d cycles", wait_limit);
        break;
      end
      @(posedge clk);
    end
    us_valid <= 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(posedge clk);
    rdreq <= 1'b1;
    @(negedge clk);
    while (pops != accepts || !empty) begin
      n++;
      if (n > wait_limit) begin
        tb_errors++;
        $display("The FIFO did not drain within %0d cycles", wait_limit);
        break;
      end
      @(negedge clk);
    end
    @(posedge clk);
    rdreq <= 1'b0;
  endtask

  task automatic check_latency();
    int n;
    send_one();
    n = 1;
    @(posedge clk);
    // empty read at an edge shows the state after the edge before
    while (empty && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (empty) begin
      tb_errors++;
      $display("The single request never reached the FIFO");
    end else if (n - 1 != `LS_PIPE_DEPTH) begin
      tb_errors++;
      $display("Fail at %0t: empty latency expected %0d, got %0d", $time, `LS_PIPE_DEPTH, n - 1);
    end
    drain();
  endtask

  task automatic check_credit_stall();
    int start_acc;
    int n;
    @(negedge clk);
    start_acc = accepts;
    repeat (3 * `LS_PIPE_DEPTH) begin
      @(posedge clk);
      set_random_req();
      us_valid <= 1'b1;
    end
    @(posedge clk);
    us_valid <= 1'b0;
    @(negedge clk);
    if (accepts - start_acc != fifo_slots) begin
      tb_errors++;
      $display("Fail at %0t: accepts expected %0d, got %0d", $time, fifo_slots,
               accepts - start_acc);
    end
    if (!us_stall) begin
      tb_errors++;
      $display("us_stall was low while the FIFO was full and no read was made");
    end
    @(posedge clk);
    rdreq <= 1'b1;
    @(posedge clk);  // pop edge
    rdreq <= 1'b0;
    n = 0;
    @(negedge clk);
    while (us_stall) begin
      n++;
      if (n > wait_limit) begin
        tb_errors++;
        $display("us_stall stayed high after a pop for %0d cycles", wait_limit);
        break;
      end
      @(negedge clk);
    end
    if (n != 0) begin
      tb_errors++;
      $display("Fail at %0t: us_stall cycles after pop expected 0, got %0d", $time, n);
    end
    drain();
  endtask

  task automatic read_while_empty();
    int start_pops;
    @(negedge clk);
    start_pops = pops;
    repeat (4) begin
      @(posedge clk);
      rdreq <= 1'b1;
    end
    @(posedge clk);
    rdreq <= 1'b0;
    @(negedge clk);
    if (pops != start_pops) begin
      tb_errors++;
      $display("Fail at %0t: pops expected %0d, got %0d", $time, start_pops, pops);
    end
    if (!empty) begin
      tb_errors++;
      $display("empty went low although nothing was written");
    end
  endtask

  task automatic run_traffic(input int cycles, input int valid_pct, input int read_pct);
    repeat (cycles) begin
      @(posedge clk);
      set_random_req();
      us_valid <= ($urandom_range(0, 99) < valid_pct);
      rdreq <= ($urandom_range(0, 99) < read_pct);
    end
    @(posedge clk);
    us_valid <= 1'b0;
    rdreq <= 1'b0;
  endtask

  initial begin
    int total;
    void'($urandom(32'h1673_9220));
    rst = 1'b1;
    us_valid = 1'b0;
    us_req = '0;
    us_tag = '0;
    rdreq = 1'b0;
    tb_errors = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    check_latency();
    check_credit_stall();
    read_while_empty();
    send_one();
    send_one();
    drain();

    run_traffic(200, 60, 0);    // no reads so credits hold upstream off
    drain();
    run_traffic(300, 70, 90);   // dense reads
    run_traffic(400, 50, 50);   // mixed
    drain();

    total = chk_errors + tb_errors;
    $display("checker errors %0d, testbench errors %0d, accepts %0d, pops %0d",
             chk_errors, tb_errors, accepts, pops);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
